/* arp_offload_pkg.sv */
package arp_offload_pkg;

   // Stream widths
   localparam int DATA_WIDTH = 256;
   localparam int KEEP_WIDTH = DATA_WIDTH / 8;
   localparam int USER_WIDTH = 128;

   // Register bus widths
   localparam int AXIL_ADDR_WIDTH = 8;
   localparam int AXIL_DATA_WIDTH = 32;

   // Field positions in tuser and tdata
   localparam int SRC_PORT_LSB  = 16;
   localparam int ETHERTYPE_LSB = 96;

   // Packet marks, byte swapped as the ethertype sits in tdata
   localparam logic [7:0]  PAYLOAD_PORT  = 8'hFF;
   localparam logic [15:0] ARP_ETHERTYPE = 16'h0608;
   localparam logic [31:0] META_MAGIC    = 32'hA5A5_A5A5;

   // Chunking of the stored object
   localparam logic [31:0] MAX_CHUNK = 32'd1436;
   localparam logic [15:0] HDR_BYTES = 16'd64;

   localparam logic [31:0] ID_VALUE = 32'h0A59_0001;

   typedef enum logic [2:0] {
      st_idle,
      st_pass,
      st_store,
      st_meta,
      st_drain,
      st_append
   } inject_state_t;

   typedef enum logic [AXIL_ADDR_WIDTH-1:0] {
      reg_id     = 8'h00,
      reg_ctrl   = 8'h04,
      reg_size   = 8'h08,
      reg_pktin  = 8'h0C,
      reg_pktout = 8'h10
   } reg_addr_t;

endpackage

/* axis_beat_if.sv */
`timescale 1ns/1ps

interface axis_beat_if;
   import arp_offload_pkg::*;

   logic [DATA_WIDTH-1:0] tdata;
   logic [KEEP_WIDTH-1:0] tkeep;
   logic [USER_WIDTH-1:0] tuser;
   logic                  tlast;
   logic                  tvalid;
   logic                  tready;

   // Beat producer
   modport src (
      output tdata, tkeep, tuser, tlast, tvalid,
      input  tready
   );

   // Beat consumer
   modport dst (
      input  tdata, tkeep, tuser, tlast, tvalid,
      output tready
   );

   modport monitor (
      input tdata, tkeep, tuser, tlast, tvalid, tready
   );

endinterface

/* beat_fifo.sv */
`timescale 1ns/1ps

module beat_fifo #(
   parameter int DEPTH = 16
) (
   input  logic        axis_aclk,
   input  logic        axis_resetn,
   axis_beat_if.dst    wr,
   axis_beat_if.src    rd
);
   import arp_offload_pkg::*;

   localparam int BEAT_WIDTH = DATA_WIDTH + KEEP_WIDTH + USER_WIDTH + 1;
   localparam int PTR_WIDTH  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_WIDTH  = $clog2(DEPTH + 1);

   logic [BEAT_WIDTH-1:0] mem [DEPTH];
   logic [PTR_WIDTH-1:0]  wr_ptr;
   logic [PTR_WIDTH-1:0]  rd_ptr;
   logic [CNT_WIDTH-1:0]  count;
   logic                  push;
   logic                  pop;

   // Margin of two beats below full
   assign wr.tready = (count < CNT_WIDTH'(DEPTH - 2));
   assign push      = wr.tvalid && wr.tready;
   assign pop       = rd.tvalid && rd.tready;

   // Head beat shows without a read cycle
   assign rd.tvalid = (count != '0);
   assign {rd.tlast, rd.tuser, rd.tkeep, rd.tdata} = mem[rd_ptr];

   always_ff @(posedge axis_aclk) begin
      if (push) begin
         mem[wr_ptr] <= {wr.tlast, wr.tuser, wr.tkeep, wr.tdata};
      end
   end

   always_ff @(posedge axis_aclk) begin
      if (!axis_resetn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= (wr_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= (rd_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

/* arp_inject_fsm.sv */
`timescale 1ns/1ps

module arp_inject_fsm (
   input  logic        axis_aclk,
   input  logic        axis_resetn,
   axis_beat_if.dst    head,
   axis_beat_if.src    store_wr,
   axis_beat_if.dst    store_rd,
   axis_beat_if.src    out,
   input  logic [31:0] object_size
);
   import arp_offload_pkg::*;

   inject_state_t state;
   inject_state_t next_state;

   logic [7:0]  stored_cnt;
   logic [31:0] prev_size;
   logic [31:0] offset;
   logic [31:0] cur_offset;
   logic [31:0] remain;
   logic [31:0] chunk;
   logic        size_changed;
   logic        is_payload;
   logic        is_arp;
   logic        store_push;
   logic        store_pop;
   logic        meta_sent;

   assign is_payload = (head.tuser[SRC_PORT_LSB +: 8] == PAYLOAD_PORT);
   assign is_arp     = (head.tdata[ETHERTYPE_LSB +: 16] == ARP_ETHERTYPE);

   // A new size restarts the object at once
   assign size_changed = (object_size != prev_size);
   assign cur_offset   = size_changed ? '0 : offset;
   assign remain       = object_size - cur_offset;
   assign chunk        = (remain < MAX_CHUNK) ? remain : MAX_CHUNK;

   // Store writes always carry the head beat
   assign store_wr.tdata = head.tdata;
   assign store_wr.tkeep = head.tkeep;
   assign store_wr.tuser = head.tuser;
   assign store_wr.tlast = head.tlast;

   assign store_push = store_wr.tvalid && store_wr.tready && store_wr.tlast;
   assign store_pop  = store_rd.tvalid && store_rd.tready && store_rd.tlast;
   assign meta_sent  = (state == st_meta) && out.tvalid && out.tready;

   always_comb begin
      next_state     = state;
      head.tready    = 1'b0;
      store_wr.tvalid = 1'b0;
      store_rd.tready = 1'b0;
      out.tdata      = head.tdata;
      out.tkeep      = head.tkeep;
      out.tuser      = head.tuser;
      out.tlast      = head.tlast;
      out.tvalid     = 1'b0;

      case (state)
         st_idle: begin
            if (head.tvalid) begin
               if (is_payload) begin
                  // First beat of a payload packet is dropped
                  head.tready = 1'b1;
                  if (!head.tlast) begin
                     next_state = st_store;
                  end
               end else if (is_arp && !head.tlast && stored_cnt != '0) begin
                  out.tvalid       = 1'b1;
                  out.tuser[15:0]  = chunk[15:0] + HDR_BYTES;
                  head.tready      = out.tready;
                  if (out.tready) begin
                     next_state = st_meta;
                  end
               end else begin
                  out.tvalid  = 1'b1;
                  head.tready = out.tready;
                  if (out.tready && !head.tlast) begin
                     next_state = st_pass;
                  end
               end
            end
         end

         st_pass: begin
            out.tvalid  = head.tvalid;
            head.tready = out.tready;
            if (head.tvalid && out.tready && head.tlast) begin
               next_state = st_idle;
            end
         end

         st_store: begin
            store_wr.tvalid = head.tvalid;
            head.tready     = store_wr.tready;
            if (head.tvalid && store_wr.tready && head.tlast) begin
               next_state = st_idle;
            end
         end

         st_meta: begin
            // Metadata fields go least significant byte first
            out.tvalid           = head.tvalid;
            out.tdata            = '0;
            out.tdata[79:0]      = head.tdata[79:0];
            out.tdata[80 +: 32]  = META_MAGIC;
            out.tdata[112 +: 32] = cur_offset;
            out.tdata[144 +: 32] = object_size;
            out.tkeep            = '1;
            out.tlast            = 1'b0;
            head.tready          = out.tready;
            if (head.tvalid && out.tready) begin
               next_state = head.tlast ? st_append : st_drain;
            end
         end

         st_drain: begin
            head.tready = 1'b1;
            if (head.tvalid && head.tlast) begin
               next_state = st_append;
            end
         end

         st_append: begin
            out.tdata       = store_rd.tdata;
            out.tkeep       = store_rd.tkeep;
            out.tuser       = store_rd.tuser;
            out.tlast       = store_rd.tlast;
            out.tvalid      = store_rd.tvalid;
            store_rd.tready = out.tready;
            if (store_rd.tvalid && out.tready && store_rd.tlast) begin
               next_state = st_idle;
            end
         end

         default: next_state = st_idle;
      endcase
   end

   always_ff @(posedge axis_aclk) begin
      if (!axis_resetn) begin
         state      <= st_idle;
         stored_cnt <= '0;
         prev_size  <= '0;
         offset     <= '0;
      end else begin
         state     <= next_state;
         prev_size <= object_size;

         // Whole packets held in the store
         case ({store_push, store_pop})
            2'b10:   stored_cnt <= stored_cnt + 1'b1;
            2'b01:   stored_cnt <= stored_cnt - 1'b1;
            default: stored_cnt <= stored_cnt;
         endcase

         if (meta_sent) begin
            offset <= (cur_offset + chunk == object_size) ? '0 : cur_offset + chunk;
         end else if (size_changed) begin
            offset <= '0;
         end
      end
   end

endmodule

/* axil_regs.sv */
`timescale 1ns/1ps

module axil_regs (
   input  logic                                        axis_aclk,
   input  logic                                        axis_resetn,
   input  logic [arp_offload_pkg::AXIL_ADDR_WIDTH-1:0] s_axil_awaddr,
   input  logic                                        s_axil_awvalid,
   output logic                                        s_axil_awready,
   input  logic [arp_offload_pkg::AXIL_DATA_WIDTH-1:0] s_axil_wdata,
   input  logic                                        s_axil_wvalid,
   output logic                                        s_axil_wready,
   output logic [1:0]                                  s_axil_bresp,
   output logic                                        s_axil_bvalid,
   input  logic                                        s_axil_bready,
   input  logic [arp_offload_pkg::AXIL_ADDR_WIDTH-1:0] s_axil_araddr,
   input  logic                                        s_axil_arvalid,
   output logic                                        s_axil_arready,
   output logic [arp_offload_pkg::AXIL_DATA_WIDTH-1:0] s_axil_rdata,
   output logic [1:0]                                  s_axil_rresp,
   output logic                                        s_axil_rvalid,
   input  logic                                        s_axil_rready,
   axis_beat_if.monitor                                pkt_in,
   axis_beat_if.monitor                                pkt_out,
   output logic [31:0]                                 object_size
);
   import arp_offload_pkg::*;

   logic [AXIL_DATA_WIDTH-1:0] size_reg;
   logic [31:0]                pktin_cnt;
   logic [31:0]                pktout_cnt;
   logic                       wr_en;
   logic                       clear_cnt;
   logic                       in_done;
   logic                       out_done;

   assign s_axil_bresp = 2'b00;
   assign s_axil_rresp = 2'b00;
   assign object_size  = size_reg;

   // Address and data are taken in the cycle the ready pulses
   assign wr_en     = s_axil_awready;
   assign clear_cnt = wr_en && (s_axil_awaddr == reg_ctrl) && s_axil_wdata[0];

   assign in_done  = pkt_in.tvalid && pkt_in.tready && pkt_in.tlast;
   assign out_done = pkt_out.tvalid && pkt_out.tready && pkt_out.tlast;

   // Write channel
   always_ff @(posedge axis_aclk) begin
      if (!axis_resetn) begin
         s_axil_awready <= 1'b0;
         s_axil_wready  <= 1'b0;
         s_axil_bvalid  <= 1'b0;
         size_reg       <= '0;
      end else begin
         s_axil_awready <= 1'b0;
         s_axil_wready  <= 1'b0;
         if (s_axil_awvalid && s_axil_wvalid && !s_axil_bvalid && !s_axil_awready) begin
            s_axil_awready <= 1'b1;
            s_axil_wready  <= 1'b1;
         end
         if (s_axil_awready) begin
            s_axil_bvalid <= 1'b1;
         end else if (s_axil_bready) begin
            s_axil_bvalid <= 1'b0;
         end
         if (wr_en && s_axil_awaddr == reg_size) begin
            size_reg <= s_axil_wdata;
         end
      end
   end

   // Read channel
   always_ff @(posedge axis_aclk) begin
      if (!axis_resetn) begin
         s_axil_arready <= 1'b0;
         s_axil_rvalid  <= 1'b0;
      end else begin
         s_axil_arready <= s_axil_arvalid && !s_axil_arready && !s_axil_rvalid;
         if (s_axil_arready) begin
            s_axil_rvalid <= 1'b1;
         end else if (s_axil_rready) begin
            s_axil_rvalid <= 1'b0;
         end
      end
   end

   always_ff @(posedge axis_aclk) begin
      if (s_axil_arready) begin
         case (s_axil_araddr)
            reg_id:     s_axil_rdata <= ID_VALUE;
            reg_size:   s_axil_rdata <= size_reg;
            reg_pktin:  s_axil_rdata <= pktin_cnt;
            reg_pktout: s_axil_rdata <= pktout_cnt;
            default:    s_axil_rdata <= '0;
         endcase
      end
   end

   // Packet counters wrap around
   always_ff @(posedge axis_aclk) begin
      if (!axis_resetn || clear_cnt) begin
         pktin_cnt  <= '0;
         pktout_cnt <= '0;
      end else begin
         pktin_cnt  <= pktin_cnt + {31'd0, in_done};
         pktout_cnt <= pktout_cnt + {31'd0, out_done};
      end
   end

endmodule

/* arp_offload.sv */
`timescale 1ns/1ps

module arp_offload #(
   parameter int IN_DEPTH    = 16,
   parameter int STORE_DEPTH = 64
) (
   input  logic                                        axis_aclk,
   input  logic                                        axis_resetn,
   input  logic [arp_offload_pkg::DATA_WIDTH-1:0]      s_axis_tdata,
   input  logic [arp_offload_pkg::KEEP_WIDTH-1:0]      s_axis_tkeep,
   input  logic [arp_offload_pkg::USER_WIDTH-1:0]      s_axis_tuser,
   input  logic                                        s_axis_tlast,
   input  logic                                        s_axis_tvalid,
   output logic                                        s_axis_tready,
   output logic [arp_offload_pkg::DATA_WIDTH-1:0]      m_axis_tdata,
   output logic [arp_offload_pkg::KEEP_WIDTH-1:0]      m_axis_tkeep,
   output logic [arp_offload_pkg::USER_WIDTH-1:0]      m_axis_tuser,
   output logic                                        m_axis_tlast,
   output logic                                        m_axis_tvalid,
   input  logic                                        m_axis_tready,
   input  logic [arp_offload_pkg::AXIL_ADDR_WIDTH-1:0] s_axil_awaddr,
   input  logic                                        s_axil_awvalid,
   output logic                                        s_axil_awready,
   input  logic [arp_offload_pkg::AXIL_DATA_WIDTH-1:0] s_axil_wdata,
   input  logic                                        s_axil_wvalid,
   output logic                                        s_axil_wready,
   output logic [1:0]                                  s_axil_bresp,
   output logic                                        s_axil_bvalid,
   input  logic                                        s_axil_bready,
   input  logic [arp_offload_pkg::AXIL_ADDR_WIDTH-1:0] s_axil_araddr,
   input  logic                                        s_axil_arvalid,
   output logic                                        s_axil_arready,
   output logic [arp_offload_pkg::AXIL_DATA_WIDTH-1:0] s_axil_rdata,
   output logic [1:0]                                  s_axil_rresp,
   output logic                                        s_axil_rvalid,
   input  logic                                        s_axil_rready
);

   axis_beat_if in_if ();
   axis_beat_if head_if ();
   axis_beat_if store_wr_if ();
   axis_beat_if store_rd_if ();
   axis_beat_if out_if ();

   logic [31:0] object_size;

   // Slave stream side
   assign in_if.tdata   = s_axis_tdata;
   assign in_if.tkeep   = s_axis_tkeep;
   assign in_if.tuser   = s_axis_tuser;
   assign in_if.tlast   = s_axis_tlast;
   assign in_if.tvalid  = s_axis_tvalid;
   assign s_axis_tready = in_if.tready;

   // Master stream side
   assign m_axis_tdata  = out_if.tdata;
   assign m_axis_tkeep  = out_if.tkeep;
   assign m_axis_tuser  = out_if.tuser;
   assign m_axis_tlast  = out_if.tlast;
   assign m_axis_tvalid = out_if.tvalid;
   assign out_if.tready = m_axis_tready;

   beat_fifo #(.DEPTH(IN_DEPTH)) in_fifo (
      .axis_aclk   (axis_aclk),
      .axis_resetn (axis_resetn),
      .wr          (in_if.dst),
      .rd          (head_if.src)
   );

   beat_fifo #(.DEPTH(STORE_DEPTH)) store_fifo (
      .axis_aclk   (axis_aclk),
      .axis_resetn (axis_resetn),
      .wr          (store_wr_if.dst),
      .rd          (store_rd_if.src)
   );

   arp_inject_fsm arp_inject_fsm_inst (
      .axis_aclk   (axis_aclk),
      .axis_resetn (axis_resetn),
      .head        (head_if.dst),
      .store_wr    (store_wr_if.src),
      .store_rd    (store_rd_if.dst),
      .out         (out_if.src),
      .object_size (object_size)
   );

   axil_regs axil_regs_inst (
      .axis_aclk      (axis_aclk),
      .axis_resetn    (axis_resetn),
      .s_axil_awaddr  (s_axil_awaddr),
      .s_axil_awvalid (s_axil_awvalid),
      .s_axil_awready (s_axil_awready),
      .s_axil_wdata   (s_axil_wdata),
      .s_axil_wvalid  (s_axil_wvalid),
      .s_axil_wready  (s_axil_wready),
      .s_axil_bresp   (s_axil_bresp),
      .s_axil_bvalid  (s_axil_bvalid),
      .s_axil_bready  (s_axil_bready),
      .s_axil_araddr  (s_axil_araddr),
      .s_axil_arvalid (s_axil_arvalid),
      .s_axil_arready (s_axil_arready),
      .s_axil_rdata   (s_axil_rdata),
      .s_axil_rresp   (s_axil_rresp),
      .s_axil_rvalid  (s_axil_rvalid),
      .s_axil_rready  (s_axil_rready),
      .pkt_in         (in_if.monitor),
      .pkt_out        (out_if.monitor),
      .object_size    (object_size)
   );

endmodule

/* arp_offload_chk.sv */
`timescale 1ns/1ps

module arp_offload_chk (
   input logic                                   axis_aclk,
   input logic                                   axis_resetn,
   input logic [arp_offload_pkg::DATA_WIDTH-1:0] m_axis_tdata,
   input logic [arp_offload_pkg::KEEP_WIDTH-1:0] m_axis_tkeep,
   input logic [arp_offload_pkg::USER_WIDTH-1:0] m_axis_tuser,
   input logic                                   m_axis_tlast,
   input logic                                   m_axis_tvalid,
   input logic                                   m_axis_tready,
   input logic                                   s_axil_bvalid,
   input logic                                   s_axil_bready,
   input logic                                   s_axil_rvalid,
   input logic                                   s_axil_rready
);

   // Output beat stays put while the sink stalls
   assert property (@(posedge axis_aclk) disable iff (!axis_resetn)
      m_axis_tvalid && !m_axis_tready |=> m_axis_tvalid &&
      $stable({m_axis_tdata, m_axis_tkeep, m_axis_tuser, m_axis_tlast}))
      else $error("m_axis beat changed or dropped while stalled");

   assert property (@(posedge axis_aclk) disable iff (!axis_resetn)
      s_axil_bvalid && !s_axil_bready |=> s_axil_bvalid)
      else $error("bvalid dropped before bready");

   assert property (@(posedge axis_aclk) disable iff (!axis_resetn)
      s_axil_rvalid && !s_axil_rready |=> s_axil_rvalid)
      else $error("rvalid dropped before rready");

   // No output while held in reset
   assert property (@(posedge axis_aclk) !axis_resetn |=> !m_axis_tvalid)
      else $error("m_axis_tvalid high during reset");

endmodule

/* arp_offload_tb.sv */
`timescale 1ns/1ps

module arp_offload_tb;
   import arp_offload_pkg::*;

   localparam int NUM_RAND_PKTS = 24;
   // Upper bound on stimulus beats over all tests
   localparam int MAX_BEATS     = NUM_RAND_PKTS * 4 + 64;
   localparam int LIMIT_CYCLES  = MAX_BEATS * 40 + 2000;

   logic                       axis_aclk      = 1'b0;
   logic                       axis_resetn    = 1'b0;
   logic [DATA_WIDTH-1:0]      s_axis_tdata   = '0;
   logic [KEEP_WIDTH-1:0]      s_axis_tkeep   = '0;
   logic [USER_WIDTH-1:0]      s_axis_tuser   = '0;
   logic                       s_axis_tlast   = 1'b0;
   logic                       s_axis_tvalid  = 1'b0;
   logic                       s_axis_tready;
   logic [DATA_WIDTH-1:0]      m_axis_tdata;
   logic [KEEP_WIDTH-1:0]      m_axis_tkeep;
   logic [USER_WIDTH-1:0]      m_axis_tuser;
   logic                       m_axis_tlast;
   logic                       m_axis_tvalid;
   logic                       m_axis_tready  = 1'b1;
   logic [AXIL_ADDR_WIDTH-1:0] s_axil_awaddr  = '0;
   logic                       s_axil_awvalid = 1'b0;
   logic                       s_axil_awready;
   logic [AXIL_DATA_WIDTH-1:0] s_axil_wdata   = '0;
   logic                       s_axil_wvalid  = 1'b0;
   logic                       s_axil_wready;
   logic [1:0]                 s_axil_bresp;
   logic                       s_axil_bvalid;
   logic                       s_axil_bready  = 1'b0;
   logic [AXIL_ADDR_WIDTH-1:0] s_axil_araddr  = '0;
   logic                       s_axil_arvalid = 1'b0;
   logic                       s_axil_arready;
   logic [AXIL_DATA_WIDTH-1:0] s_axil_rdata;
   logic [1:0]                 s_axil_rresp;
   logic                       s_axil_rvalid;
   logic                       s_axil_rready  = 1'b0;

   // Packet under construction
   logic [DATA_WIDTH-1:0] pk_data [$];
   logic [KEEP_WIDTH-1:0] pk_keep [$];
   logic [USER_WIDTH-1:0] pk_user [$];
   logic                  pk_last [$];
   // Expected output beats
   logic [DATA_WIDTH-1:0] exp_data [$];
   logic [KEEP_WIDTH-1:0] exp_keep [$];
   logic [USER_WIDTH-1:0] exp_user [$];
   logic                  exp_last [$];
   // Reference model of the payload store
   logic [DATA_WIDTH-1:0] st_data [$];
   logic [KEEP_WIDTH-1:0] st_keep [$];
   logic [USER_WIDTH-1:0] st_user [$];
   logic                  st_last [$];

   logic [31:0] stim_seed    = 32'd23523;
   logic [31:0] bp_seed      = 32'd23523;
   logic [31:0] model_size   = '0;
   logic [31:0] model_offset = '0;
   logic        stall_en     = 1'b0;
   int          stored_pkts  = 0;
   int          tx_pkts      = 0;
   int          exp_pkts     = 0;

   arp_offload arp_offload_inst (.*);

   bind arp_offload arp_offload_chk chk_inst (
      .axis_aclk     (axis_aclk),
      .axis_resetn   (axis_resetn),
      .m_axis_tdata  (m_axis_tdata),
      .m_axis_tkeep  (m_axis_tkeep),
      .m_axis_tuser  (m_axis_tuser),
      .m_axis_tlast  (m_axis_tlast),
      .m_axis_tvalid (m_axis_tvalid),
      .m_axis_tready (m_axis_tready),
      .s_axil_bvalid (s_axil_bvalid),
      .s_axil_bready (s_axil_bready),
      .s_axil_rvalid (s_axil_rvalid),
      .s_axil_rready (s_axil_rready)
   );

   always #4 axis_aclk = ~axis_aclk;

   function automatic logic [31:0] lcg_step(input logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   function automatic logic [31:0] next_stim();
      stim_seed = lcg_step(stim_seed);
      return stim_seed;
   endfunction

   task automatic end_with_failure();
      $display("Testbench failed");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [DATA_WIDTH-1:0] exp_val,
                              input logic [DATA_WIDTH-1:0] act_val);
      assert (act_val === exp_val)
         else begin
            $display("ERROR %s expected %0h actual %0h", name, exp_val, act_val);
            end_with_failure();
         end
   endtask

   function automatic void expect_beat(input logic [DATA_WIDTH-1:0] d,
                                       input logic [KEEP_WIDTH-1:0] k,
                                       input logic [USER_WIDTH-1:0] u, input logic l);
      exp_data.push_back(d);
      exp_keep.push_back(k);
      exp_user.push_back(u);
      exp_last.push_back(l);
      if (l) begin
         exp_pkts++;
      end
   endfunction

   // Expected output of one input packet, in the order the DUT handles packets
   function automatic void model_packet();
      logic [31:0]           remain;
      logic [31:0]           chunk;
      logic [USER_WIDTH-1:0] first_user;
      logic [DATA_WIDTH-1:0] meta;
      logic                  done;
      int                    n;
      n = pk_data.size();
      if (pk_user[0][23:16] == 8'hFF) begin
         // First payload beat is dropped, the rest is stored
         for (int i = 1; i < n; i++) begin
            st_data.push_back(pk_data[i]);
            st_keep.push_back(pk_keep[i]);
            st_user.push_back(pk_user[i]);
            st_last.push_back(pk_last[i]);
         end
         if (n > 1) begin
            stored_pkts++;
         end
      end else if (pk_data[0][111:96] == 16'h0608 && n > 1 && stored_pkts != 0) begin
         remain = model_size - model_offset;
         chunk  = (remain < 32'd1436) ? remain : 32'd1436;
         first_user        = pk_user[0];
         first_user[15:0]  = chunk[15:0] + 16'd64;
         expect_beat(pk_data[0], pk_keep[0], first_user, 1'b0);
         meta          = '0;
         meta[79:0]    = pk_data[1][79:0];
         meta[111:80]  = 32'hA5A5_A5A5;
         meta[143:112] = model_offset;
         meta[175:144] = model_size;
         expect_beat(meta, '1, pk_user[1], 1'b0);
         model_offset = (model_offset + chunk == model_size) ? 32'd0 : model_offset + chunk;
         do begin
            done = st_last[0];
            expect_beat(st_data.pop_front(), st_keep.pop_front(), st_user.pop_front(),
                        st_last.pop_front());
         end while (!done);
         stored_pkts--;
      end else begin
         for (int i = 0; i < n; i++) begin
            expect_beat(pk_data[i], pk_keep[i], pk_user[i], pk_last[i]);
         end
      end
   endfunction

   task automatic build_packet(input int beats, input logic [15:0] etype, input logic [7:0] port);
      logic [DATA_WIDTH-1:0] d;
      logic [USER_WIDTH-1:0] u;
      logic [KEEP_WIDTH-1:0] k;
      for (int b = 0; b < beats; b++) begin
         for (int w = 0; w < DATA_WIDTH / 32; w++) begin
            d[w*32 +: 32] = next_stim();
         end
         for (int w = 0; w < USER_WIDTH / 32; w++) begin
            u[w*32 +: 32] = next_stim();
         end
         k = (b == beats - 1) ? next_stim() : '1;
         if (b == 0) begin
            d[111:96] = etype;
            u[23:16]  = port;
         end
         pk_data.push_back(d);
         pk_keep.push_back(k);
         pk_user.push_back(u);
         pk_last.push_back(b == beats - 1);
      end
   endtask

   task automatic send_packet();
      model_packet();
      for (int b = 0; b < pk_data.size(); b++) begin
         s_axis_tdata  = pk_data[b];
         s_axis_tkeep  = pk_keep[b];
         s_axis_tuser  = pk_user[b];
         s_axis_tlast  = pk_last[b];
         s_axis_tvalid = 1'b1;
         @(negedge axis_aclk);
         while (!s_axis_tready) begin
            @(negedge axis_aclk);
         end
         @(posedge axis_aclk);
         #1;
      end
      s_axis_tvalid = 1'b0;
      tx_pkts++;
      pk_data.delete();
      pk_keep.delete();
      pk_user.delete();
      pk_last.delete();
   endtask

   task automatic reg_write(input logic [7:0] addr, input logic [31:0] data);
      s_axil_awaddr  = addr;
      s_axil_wdata   = data;
      s_axil_awvalid = 1'b1;
      s_axil_wvalid  = 1'b1;
      @(negedge axis_aclk);
      while (!s_axil_awready) begin
         @(negedge axis_aclk);
      end
      check_value("s_axil_wready", DATA_WIDTH'(1'b1), DATA_WIDTH'(s_axil_wready));
      @(posedge axis_aclk);
      #1;
      s_axil_awvalid = 1'b0;
      s_axil_wvalid  = 1'b0;
      @(negedge axis_aclk);
      while (!s_axil_bvalid) begin
         @(negedge axis_aclk);
      end
      check_value("s_axil_bresp", '0, DATA_WIDTH'(s_axil_bresp));
      // Response is left waiting one cycle before it is taken
      @(posedge axis_aclk);
      #1;
      s_axil_bready = 1'b1;
      @(posedge axis_aclk);
      #1;
      s_axil_bready = 1'b0;
      // A new size restarts the object
      if (addr == reg_size) begin
         if (data != model_size) begin
            model_offset = '0;
         end
         model_size = data;
      end
   endtask

   task automatic reg_read(input logic [7:0] addr, output logic [31:0] data);
      s_axil_araddr  = addr;
      s_axil_arvalid = 1'b1;
      @(negedge axis_aclk);
      while (!s_axil_arready) begin
         @(negedge axis_aclk);
      end
      @(posedge axis_aclk);
      #1;
      s_axil_arvalid = 1'b0;
      @(negedge axis_aclk);
      while (!s_axil_rvalid) begin
         @(negedge axis_aclk);
      end
      check_value("s_axil_rresp", '0, DATA_WIDTH'(s_axil_rresp));
      data = s_axil_rdata;
      // Read data is left waiting one cycle before it is taken
      @(posedge axis_aclk);
      #1;
      s_axil_rready = 1'b1;
      @(posedge axis_aclk);
      #1;
      s_axil_rready = 1'b0;
   endtask

   task automatic check_register(input logic [7:0] addr, input logic [31:0] exp_val);
      logic [31:0] data;
      reg_read(addr, data);
      check_value("s_axil_rdata", DATA_WIDTH'(exp_val), DATA_WIDTH'(data));
   endtask

   task automatic wait_drained();
      while (exp_data.size() != 0) begin
         @(posedge axis_aclk);
      end
      repeat (16) @(posedge axis_aclk);
      #1;
   endtask

   // Random stalls on the output
   always @(posedge axis_aclk) begin
      #1;
      bp_seed       = lcg_step(bp_seed);
      m_axis_tready = !stall_en || (bp_seed[17:16] != 2'b00);
   end

   // Output beats are compared the half cycle before they transfer
   initial begin
      forever begin
         @(negedge axis_aclk);
         if (axis_resetn && m_axis_tvalid && m_axis_tready) begin
            if (exp_data.size() == 0) begin
               $display("Output beat arrived while no beat was expected");
               end_with_failure();
            end else begin
               check_value("m_axis_tdata", exp_data.pop_front(), m_axis_tdata);
               check_value("m_axis_tkeep", DATA_WIDTH'(exp_keep.pop_front()),
                           DATA_WIDTH'(m_axis_tkeep));
               check_value("m_axis_tuser", DATA_WIDTH'(exp_user.pop_front()),
                           DATA_WIDTH'(m_axis_tuser));
               check_value("m_axis_tlast", DATA_WIDTH'(exp_last.pop_front()),
                           DATA_WIDTH'(m_axis_tlast));
            end
         end
      end
   end

   initial begin
      repeat (LIMIT_CYCLES) @(posedge axis_aclk);
      $display("Simulation timed out before all tests finished");
      end_with_failure();
   end

   initial begin
      logic [31:0] r;
      repeat (8) @(posedge axis_aclk);
      #1;
      axis_resetn = 1'b1;
      @(negedge axis_aclk);
      check_value("m_axis_tvalid", '0, DATA_WIDTH'(m_axis_tvalid));
      check_value("s_axil_bvalid", '0, DATA_WIDTH'(s_axil_bvalid));
      check_value("s_axil_rvalid", '0, DATA_WIDTH'(s_axil_rvalid));
      check_value("s_axil_awready", '0, DATA_WIDTH'(s_axil_awready));
      check_value("s_axil_wready", '0, DATA_WIDTH'(s_axil_wready));
      check_value("s_axil_arready", '0, DATA_WIDTH'(s_axil_arready));
      @(posedge axis_aclk);
      #1;
      check_register(reg_id, 32'h0A59_0001);
      reg_write(reg_size, 32'h1234_5678);
      check_register(reg_size, 32'h1234_5678);

      // Non-ARP traffic under random stalls
      stall_en = 1'b1;
      for (int p = 0; p < NUM_RAND_PKTS; p++) begin
         r = next_stim();
         build_packet(int'(r[17:16]) + 1, 16'h0008, 8'h03);
         send_packet();
      end

      // ARP with empty store, then one-beat ARP with a stored packet
      build_packet(2, 16'h0608, 8'h03);
      send_packet();
      build_packet(3, 16'h0008, 8'hFF);
      send_packet();
      build_packet(1, 16'h0608, 8'h03);
      send_packet();
      build_packet(4, 16'h0008, 8'hFF);
      send_packet();
      build_packet(3, 16'h0608, 8'h03);
      send_packet();
      wait_drained();

      // Object of 3000 bytes in chunks
      reg_write(reg_size, 32'd3000);
      for (int p = 0; p < 3; p++) begin
         build_packet(2, 16'h0008, 8'hFF);
         send_packet();
      end
      for (int p = 0; p < 4; p++) begin
         build_packet((p % 2 == 0) ? 3 : 2, 16'h0608, 8'h03);
         send_packet();
      end
      wait_drained();
      reg_write(reg_size, 32'd4000);
      build_packet(3, 16'h0008, 8'hFF);
      send_packet();
      build_packet(3, 16'h0608, 8'h03);
      send_packet();
      wait_drained();

      check_register(reg_pktin, 32'(tx_pkts));
      check_register(reg_pktout, 32'(exp_pkts));
      reg_write(reg_ctrl, 32'd1);
      check_register(reg_pktin, 32'd0);
      check_register(reg_pktout, 32'd0);
      check_register(reg_ctrl, 32'd0);

      $display("Testbench passed");
      $finish;
   end

endmodule

/* arp_offload.f */
arp_offload_pkg.sv
axis_beat_if.sv
beat_fifo.sv
arp_inject_fsm.sv
axil_regs.sv
arp_offload.sv
arp_offload_chk.sv
arp_offload_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build with Verilator, run, then judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --assert --top-module arp_offload_tb -f arp_offload.f -o arp_offload_sim \
   && ./obj_dir/arp_offload_sim > sim.log 2>&1 \
   || echo "Build or simulation ended with an error"
cat sim.log 2>/dev/null
grep -qx "Testbench passed" sim.log && echo "Result: PASS" \
   || { echo "Result: FAIL"; exit 1; }
